// ==== hw/rob.sv ====
module rob
  import rob_pkg::*;
#(
  parameter int ENTRY_N    = 8,
  parameter int DISP_W     = 2,
  parameter int DONE_PORTS = 2
) (
  input  logic                             i_clk,
  input  logic                             i_reset_n,
  input  logic                             i_disp_valid,
  input  logic [VADDR_W-1:0]               i_disp_pc,
  input  logic [DISP_W-1:0]                i_disp_lane_valid,
  input  logic [DISP_W-1:0]                i_disp_rd_valid,
  input  logic [DISP_W-1:0][REG_W-1:0]     i_disp_rd_regidx,
  output logic [$clog2(ENTRY_N):0]         o_new_cmt_id,
  input  logic                             i_done_valid    [DONE_PORTS],
  input  logic [$clog2(ENTRY_N):0]         i_done_cmt_id   [DONE_PORTS],
  input  logic [$clog2(DISP_W)-1:0]        i_done_lane     [DONE_PORTS],
  input  logic                             i_done_redirect [DONE_PORTS],
  input  logic [VADDR_W-1:0]               i_done_target   [DONE_PORTS],
  input  logic                             i_done_except   [DONE_PORTS],
  input  except_t                          i_done_cause    [DONE_PORTS],
  output logic                             o_cmt_valid,
  output logic [$clog2(ENTRY_N):0]         o_cmt_id,
  output logic [DISP_W-1:0]                o_cmt_lanes,
  output logic [DISP_W-1:0]                o_cmt_dead_lanes,
  output logic                             o_cmt_all_dead,
  output logic                             o_cmt_flush,
  output logic [VADDR_W-1:0]               o_cmt_flush_pc,
  output logic                             o_cmt_except,
  output except_t                          o_cmt_cause,
  output logic [VADDR_W-1:0]               o_cmt_epc,
  output logic [DISP_W-1:0]                o_cmt_rd_valid,
  output logic [DISP_W-1:0][REG_W-1:0]     o_cmt_rd_regidx,
  output logic                             o_credit_ret
);

  localparam int IDX_W = $clog2(ENTRY_N);
  localparam int ID_W  = IDX_W + 1;

  logic [ID_W-1:0]  w_in_ptr, w_out_ptr;
  logic [IDX_W-1:0] w_in_idx, w_head;
  logic             w_full, w_empty, w_load, w_live, w_remain, r_kill;

  logic [ENTRY_N-1:0]                w_valid, w_dead, w_all_done;
  logic [VADDR_W-1:0]                w_pc           [ENTRY_N];
  logic [DISP_W-1:0]                 w_lane_valid   [ENTRY_N];
  logic [DISP_W-1:0]                 w_redirect     [ENTRY_N];
  logic [DISP_W-1:0][VADDR_W-1:0]    w_targets      [ENTRY_N];
  logic [DISP_W-1:0]                 w_except       [ENTRY_N];
  except_t [DISP_W-1:0]              w_causes       [ENTRY_N];
  logic [DISP_W-1:0]                 w_rd_valid     [ENTRY_N];
  logic [DISP_W-1:0][REG_W-1:0]      w_rd_regidx    [ENTRY_N];

  logic [DISP_W-1:0]  w_sel_lanes, w_sel_dead;
  logic               w_sel_flush, w_sel_except;
  logic [VADDR_W-1:0] w_sel_flush_pc;

  assign w_in_idx = w_in_ptr[IDX_W-1:0];
  assign w_head   = w_out_ptr[IDX_W-1:0];
  assign w_load   = i_disp_valid && !w_full;  // Never overwrite the head

  rob_ptr #(.ENTRY_N(ENTRY_N)) u_ptr (
    .i_clk       (i_clk),
    .i_reset_n   (i_reset_n),
    .i_in_valid  (i_disp_valid),
    .i_out_valid (o_cmt_valid),
    .o_in_ptr    (w_in_ptr),
    .o_out_ptr   (w_out_ptr),
    .o_full      (w_full),
    .o_empty     (w_empty)
  );

  for (genvar e = 0; e < ENTRY_N; e++) begin : g_entry
    rob_entry #(.ENTRY_N(ENTRY_N), .DISP_W(DISP_W), .DONE_PORTS(DONE_PORTS)) u_entry (
      .i_clk             (i_clk),
      .i_reset_n         (i_reset_n),
      .i_load_valid      (w_load && (w_in_idx == IDX_W'(e))),
      .i_load_pc         (i_disp_pc),
      .i_load_lane_valid (i_disp_lane_valid),
      .i_load_rd_valid   (i_disp_rd_valid),
      .i_load_rd_regidx  (i_disp_rd_regidx),
      .i_load_dead       (o_cmt_flush),  // Wrong path if it arrives with the flush
      .i_slot_id         (IDX_W'(e)),
      .i_done_valid      (i_done_valid),
      .i_done_cmt_id     (i_done_cmt_id),
      .i_done_lane       (i_done_lane),
      .i_done_redirect   (i_done_redirect),
      .i_done_target     (i_done_target),
      .i_done_except     (i_done_except),
      .i_done_cause      (i_done_cause),
      .i_commit_finish   (o_cmt_valid && (w_head == IDX_W'(e))),
      .i_kill            (o_cmt_flush),
      .o_valid           (w_valid[e]),
      .o_dead            (w_dead[e]),
      .o_all_done        (w_all_done[e]),
      .o_pc              (w_pc[e]),
      .o_lane_valid      (w_lane_valid[e]),
      .o_done_lanes      (),
      .o_redirect_lanes  (w_redirect[e]),
      .o_targets         (w_targets[e]),
      .o_except_lanes    (w_except[e]),
      .o_causes          (w_causes[e]),
      .o_rd_valid        (w_rd_valid[e]),
      .o_rd_regidx       (w_rd_regidx[e])
    );
  end

  rob_commit_sel #(.DISP_W(DISP_W)) u_sel (
    .i_redirect_lanes (w_redirect[w_head]),
    .i_except_lanes   (w_except[w_head]),
    .i_targets        (w_targets[w_head]),
    .i_causes         (w_causes[w_head]),
    .i_pc             (w_pc[w_head]),
    .o_sel_lanes      (w_sel_lanes),
    .o_dead_lanes     (w_sel_dead),
    .o_flush          (w_sel_flush),
    .o_flush_pc       (w_sel_flush_pc),
    .o_except         (w_sel_except),
    .o_cause          (o_cmt_cause),
    .o_epc            (o_cmt_epc)
  );

  rob_credit #(.ENTRY_N(ENTRY_N)) u_credit (
    .i_clk        (i_clk),
    .i_reset_n    (i_reset_n),
    .i_disp_valid (i_disp_valid),
    .i_commit     (o_cmt_valid),
    .o_credit_ret (o_credit_ret)
  );

  assign o_new_cmt_id   = w_in_ptr;
  assign o_cmt_valid    = w_all_done[w_head];  // Dead heads count as done
  assign o_cmt_id       = w_out_ptr;
  assign o_cmt_lanes    = w_lane_valid[w_head];
  assign o_cmt_all_dead = w_valid[w_head] && w_dead[w_head];
  assign w_live         = o_cmt_valid && !w_dead[w_head];

  assign o_cmt_dead_lanes = w_lane_valid[w_head] & (o_cmt_all_dead ? '1 : w_sel_dead);
  assign o_cmt_flush      = w_live && w_sel_flush;
  assign o_cmt_flush_pc   = o_cmt_flush ? w_sel_flush_pc : '0;
  assign o_cmt_except     = w_live && w_sel_except;

  // Trapping lane and everything after it leave the register file alone
  assign o_cmt_rd_valid  = {DISP_W{w_live}} & w_rd_valid[w_head] & w_lane_valid[w_head] &
                           ~w_sel_dead & ~(w_sel_lanes & w_except[w_head]);
  assign o_cmt_rd_regidx = w_rd_regidx[w_head];

  // Younger groups still in flight after the flushing one
  assign w_remain = (w_in_ptr != ID_W'(w_out_ptr + 1'b1)) || i_disp_valid;

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_kill <= 1'b0;
    end else if (o_cmt_flush && w_remain) begin
      r_kill <= 1'b1;
    end else if (r_kill && (w_empty || !w_dead[w_head])) begin
      r_kill <= 1'b0;
    end
  end

  a_dead_in_kill: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    o_cmt_valid && o_cmt_all_dead |-> r_kill);

endmodule

// ==== hw/rob_commit_sel.sv ====
module rob_commit_sel
  import rob_pkg::*;
#(
  parameter int DISP_W = 2
) (
  input  logic [DISP_W-1:0]                i_redirect_lanes,
  input  logic [DISP_W-1:0]                i_except_lanes,
  input  logic [DISP_W-1:0][VADDR_W-1:0]   i_targets,
  input  except_t [DISP_W-1:0]             i_causes,
  input  logic [VADDR_W-1:0]               i_pc,
  output logic [DISP_W-1:0]                o_sel_lanes,
  output logic [DISP_W-1:0]                o_dead_lanes,
  output logic                             o_flush,
  output logic [VADDR_W-1:0]               o_flush_pc,
  output logic                             o_except,
  output except_t                          o_cause,
  output logic [VADDR_W-1:0]               o_epc
);

  localparam int LANE_W = $clog2(DISP_W);

  logic [DISP_W-1:0]  w_any;
  logic [VADDR_W-1:0] w_target;
  except_t            w_cause;
  logic [LANE_W-1:0]  w_lane;

  assign w_any       = i_redirect_lanes | i_except_lanes;
  assign o_sel_lanes = w_any & (~w_any + 1'b1);  // Lowest set bit

  // Everything younger than the first redirect or trap
  always_comb begin
    logic seen;
    seen = 1'b0;
    for (int i = 0; i < DISP_W; i++) begin
      o_dead_lanes[i] = seen;
      seen = seen | w_any[i];
    end
  end

  always_comb begin
    w_target = '0;
    w_cause  = INST_MISALIGN;
    w_lane   = '0;
    for (int i = 0; i < DISP_W; i++) begin
      if (o_sel_lanes[i]) begin
        w_target = i_targets[i];
        w_cause  = i_causes[i];
        w_lane   = LANE_W'(i);
      end
    end
  end

  assign o_flush  = |w_any;
  assign o_except = |(o_sel_lanes & i_except_lanes);  // Trap beats redirect on same lane

  assign o_flush_pc = o_except ? '0 : w_target;
  assign o_cause    = o_except ? w_cause : INST_MISALIGN;
  assign o_epc      = o_except ? i_pc + VADDR_W'({w_lane, 2'b00}) : '0;

endmodule

// ==== hw/rob_credit.sv ====
module rob_credit #(
  parameter int ENTRY_N = 8
) (
  input  logic i_clk,
  input  logic i_reset_n,
  input  logic i_disp_valid,
  input  logic i_commit,
  output logic o_credit_ret
);

  localparam int CNT_W = $clog2(ENTRY_N) + 1;

  logic [CNT_W-1:0] r_outstanding;  // Groups holding a credit

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      o_credit_ret <= 1'b0;
    end else begin
      o_credit_ret <= i_commit;
    end
  end

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_outstanding <= '0;
    end else begin
      case ({i_disp_valid, o_credit_ret})
        2'b10:   r_outstanding <= r_outstanding + 1'b1;
        2'b01:   r_outstanding <= r_outstanding - 1'b1;
        default: r_outstanding <= r_outstanding;
      endcase
    end
  end

  a_credit_max: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    r_outstanding <= CNT_W'(ENTRY_N));
  a_credit_underflow: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    o_credit_ret && !i_disp_valid |-> r_outstanding != '0);

endmodule

// ==== hw/rob_entry.sv ====
module rob_entry
  import rob_pkg::*;
#(
  parameter int ENTRY_N    = 8,
  parameter int DISP_W     = 2,
  parameter int DONE_PORTS = 2
) (
  input  logic                             i_clk,
  input  logic                             i_reset_n,
  input  logic                             i_load_valid,
  input  logic [VADDR_W-1:0]               i_load_pc,
  input  logic [DISP_W-1:0]                i_load_lane_valid,
  input  logic [DISP_W-1:0]                i_load_rd_valid,
  input  logic [DISP_W-1:0][REG_W-1:0]     i_load_rd_regidx,
  input  logic                             i_load_dead,
  input  logic [$clog2(ENTRY_N)-1:0]       i_slot_id,
  input  logic                             i_done_valid    [DONE_PORTS],
  input  logic [$clog2(ENTRY_N):0]         i_done_cmt_id   [DONE_PORTS],
  input  logic [$clog2(DISP_W)-1:0]        i_done_lane     [DONE_PORTS],
  input  logic                             i_done_redirect [DONE_PORTS],
  input  logic [VADDR_W-1:0]               i_done_target   [DONE_PORTS],
  input  logic                             i_done_except   [DONE_PORTS],
  input  except_t                          i_done_cause    [DONE_PORTS],
  input  logic                             i_commit_finish,
  input  logic                             i_kill,
  output logic                             o_valid,
  output logic                             o_dead,
  output logic                             o_all_done,
  output logic [VADDR_W-1:0]               o_pc,
  output logic [DISP_W-1:0]                o_lane_valid,
  output logic [DISP_W-1:0]                o_done_lanes,
  output logic [DISP_W-1:0]                o_redirect_lanes,
  output logic [DISP_W-1:0][VADDR_W-1:0]   o_targets,
  output logic [DISP_W-1:0]                o_except_lanes,
  output except_t [DISP_W-1:0]             o_causes,
  output logic [DISP_W-1:0]                o_rd_valid,
  output logic [DISP_W-1:0][REG_W-1:0]     o_rd_regidx
);

  localparam int IDX_W = $clog2(ENTRY_N);

  logic [DONE_PORTS-1:0] w_hit;

  always_comb begin
    for (int p = 0; p < DONE_PORTS; p++) begin
      w_hit[p] = i_done_valid[p] && o_valid && (i_done_cmt_id[p][IDX_W-1:0] == i_slot_id);
    end
  end

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      o_valid          <= 1'b0;
      o_dead           <= 1'b0;
      o_done_lanes     <= '0;
      o_redirect_lanes <= '0;
      o_except_lanes   <= '0;
    end else if (i_load_valid) begin
      o_valid          <= 1'b1;
      o_dead           <= i_load_dead;
      o_done_lanes     <= ~i_load_lane_valid;  // Empty lanes count as done
      o_redirect_lanes <= '0;
      o_except_lanes   <= '0;
    end else if (i_commit_finish) begin
      o_valid          <= 1'b0;
      o_dead           <= 1'b0;
      o_redirect_lanes <= '0;
      o_except_lanes   <= '0;
    end else begin
      if (i_kill && o_valid) o_dead <= 1'b1;
      for (int p = 0; p < DONE_PORTS; p++) begin
        if (w_hit[p]) begin
          o_done_lanes[i_done_lane[p]] <= 1'b1;
          if (i_done_redirect[p]) o_redirect_lanes[i_done_lane[p]] <= 1'b1;
          if (i_done_except[p]) o_except_lanes[i_done_lane[p]] <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_load_valid) begin
      o_pc         <= i_load_pc;
      o_lane_valid <= i_load_lane_valid;
      o_rd_valid   <= i_load_rd_valid;
      o_rd_regidx  <= i_load_rd_regidx;
    end
    for (int p = 0; p < DONE_PORTS; p++) begin
      if (w_hit[p] && i_done_redirect[p]) o_targets[i_done_lane[p]] <= i_done_target[p];
      if (w_hit[p] && i_done_except[p]) o_causes[i_done_lane[p]] <= i_done_cause[p];
    end
  end

  assign o_all_done = o_valid && (o_dead || (&o_done_lanes));

  // A lane is reported once per dispatch
  for (genvar p = 0; p < DONE_PORTS; p++) begin : g_done_once
    a_done_once: assert property (@(posedge i_clk) disable iff (!i_reset_n)
      w_hit[p] |-> !o_done_lanes[i_done_lane[p]]);
  end

endmodule

// ==== hw/rob_pkg.sv ====
package rob_pkg;

  localparam int VADDR_W = 32;  // One word
  localparam int REG_W   = 5;   // Architectural register index

  // Cause codes follow the RISC-V mcause numbering
  typedef enum logic [3:0] {
    INST_MISALIGN = 4'd0,
    ILLEGAL_INST  = 4'd2,
    BREAKPOINT    = 4'd3,
    LOAD_FAULT    = 4'd5,
    STORE_FAULT   = 4'd7,
    ECALL         = 4'd11   // From machine mode
  } except_t;

endpackage

// ==== hw/rob_ptr.sv ====
module rob_ptr #(
  parameter int ENTRY_N = 8
) (
  input  logic                     i_clk,
  input  logic                     i_reset_n,
  input  logic                     i_in_valid,
  input  logic                     i_out_valid,
  output logic [$clog2(ENTRY_N):0] o_in_ptr,
  output logic [$clog2(ENTRY_N):0] o_out_ptr,
  output logic                     o_full,
  output logic                     o_empty
);

  localparam int IDX_W = $clog2(ENTRY_N);

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      o_in_ptr  <= '0;
      o_out_ptr <= '0;
    end else begin
      if (i_in_valid) o_in_ptr <= o_in_ptr + 1'b1;    // Carry into the wrap bit
      if (i_out_valid) o_out_ptr <= o_out_ptr + 1'b1;
    end
  end

  // Same slot, wrap bits tell full from empty
  assign o_empty = (o_in_ptr == o_out_ptr);
  assign o_full  = (o_in_ptr[IDX_W] != o_out_ptr[IDX_W]) &&
                   (o_in_ptr[IDX_W-1:0] == o_out_ptr[IDX_W-1:0]);

  // Dispatch must hold a credit, commit needs a valid head
  a_no_disp_full: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    !(i_in_valid && o_full));
  a_no_cmt_empty: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    !(i_out_valid && o_empty));

endmodule

// ==== tb.f ====
hw/rob_pkg.sv
hw/rob_ptr.sv
hw/rob_entry.sv
hw/rob_commit_sel.sv
hw/rob_credit.sv
hw/rob.sv
tb/rob_tb.sv

// ==== tb/rob_tb.sv ====
module rob_tb
  import rob_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int ENTRY_N = 8;
  localparam int DISP_W  = 2;
  localparam int PORTS   = 2;
  localparam logic [1:0] K_IDLE = 2'd0, K_DISP = 2'd1, K_DONE = 2'd2;

  typedef struct packed {
    logic [1:0]  kind;
    logic [7:0]  grp;
    logic [31:0] pc;
    logic [1:0]  lanes, rdv;
    logic [4:0]  rd0, rd1;
    logic        lane, port, redir, exc;
    logic [31:0] target;
    logic [3:0]  cause;
  } step_t;

  logic clk, reset_n, disp_valid;
  logic [31:0] disp_pc;
  logic [1:0] disp_lane_valid, disp_rd_valid;
  logic [1:0][4:0] disp_rd_regidx;
  logic [3:0] new_cmt_id;
  logic done_valid [PORTS];
  logic [3:0] done_cmt_id [PORTS];
  logic [0:0] done_lane [PORTS];
  logic done_redirect [PORTS];
  logic [31:0] done_target [PORTS];
  logic done_except [PORTS];
  except_t done_cause [PORTS];
  logic cmt_valid, cmt_all_dead, cmt_flush, cmt_except, credit_ret;
  logic [3:0] cmt_id;
  logic [1:0] cmt_lanes, cmt_dead_lanes, cmt_rd_valid;
  logic [31:0] cmt_flush_pc, cmt_epc;
  except_t cmt_cause;
  logic [1:0][4:0] cmt_rd_regidx;

  step_t steps [256];
  int n_steps, n_disp, value_errs, other_errs, commits, credits, head;
  bit table_ready, prev_cmt, flushed;
  integer seed;
  logic [3:0] m_in_id;

  // Reference model, indexed by dispatch order
  logic [31:0] g_pc [64];
  logic [3:0] g_id [64];
  logic [1:0] g_lanes [64], g_rdv [64], g_done [64], g_redir [64], g_exc [64];
  logic [4:0] g_rd [64][DISP_W];
  logic [31:0] g_tgt [64][DISP_W];
  logic [3:0] g_cause [64][DISP_W];
  bit g_dead [64];
  int q [$];

  rob #(.ENTRY_N(ENTRY_N), .DISP_W(DISP_W), .DONE_PORTS(PORTS)) dut (
    .i_clk(clk), .i_reset_n(reset_n), .i_disp_valid(disp_valid), .i_disp_pc(disp_pc),
    .i_disp_lane_valid(disp_lane_valid), .i_disp_rd_valid(disp_rd_valid),
    .i_disp_rd_regidx(disp_rd_regidx), .o_new_cmt_id(new_cmt_id),
    .i_done_valid(done_valid), .i_done_cmt_id(done_cmt_id), .i_done_lane(done_lane),
    .i_done_redirect(done_redirect), .i_done_target(done_target),
    .i_done_except(done_except), .i_done_cause(done_cause),
    .o_cmt_valid(cmt_valid), .o_cmt_id(cmt_id), .o_cmt_lanes(cmt_lanes),
    .o_cmt_dead_lanes(cmt_dead_lanes), .o_cmt_all_dead(cmt_all_dead),
    .o_cmt_flush(cmt_flush), .o_cmt_flush_pc(cmt_flush_pc), .o_cmt_except(cmt_except),
    .o_cmt_cause(cmt_cause), .o_cmt_epc(cmt_epc), .o_cmt_rd_valid(cmt_rd_valid),
    .o_cmt_rd_regidx(cmt_rd_regidx), .o_credit_ret(credit_ret)
  );

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("Fail %s got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
      value_errs++;
    end
  endtask

  task automatic add_disp(input logic [31:0] pc, input logic [1:0] lanes, rdv,
                          input logic [4:0] rd0, rd1);
    steps[n_steps] = '0;
    steps[n_steps].kind = K_DISP;
    steps[n_steps].pc = pc;
    steps[n_steps].lanes = lanes;
    steps[n_steps].rdv = rdv;
    steps[n_steps].rd0 = rd0;
    steps[n_steps].rd1 = rd1;
    n_steps++;
  endtask

  task automatic add_done(input int grp, input logic lane, port, redir,
                          input logic [31:0] target, input logic exc, input except_t cause);
    steps[n_steps] = '0;
    steps[n_steps].kind = K_DONE;
    steps[n_steps].grp = 8'(grp);
    steps[n_steps].lane = lane;
    steps[n_steps].port = port;
    steps[n_steps].redir = redir;
    steps[n_steps].target = target;
    steps[n_steps].exc = exc;
    steps[n_steps].cause = cause;
    n_steps++;
  endtask

  task automatic add_idle(input int n);
    repeat (n) begin
      steps[n_steps] = '0;
      steps[n_steps].kind = K_IDLE;
      n_steps++;
    end
  endtask

  task automatic build_table();
    int pg [16], pl [16], np, j, t;
    logic [1:0] lv;
    integer r;
    // Reverse done order, lane 1 of group 1 never dispatched
    add_disp(32'h1000, 2'b11, 2'b11, 5'd1, 5'd2);
    add_disp(32'h1008, 2'b01, 2'b11, 5'd3, 5'd4);
    add_disp(32'h1010, 2'b11, 2'b10, 5'd5, 5'd6);
    add_done(2, 1, 0, 0, 0, 0, INST_MISALIGN);
    add_done(2, 0, 1, 0, 0, 0, INST_MISALIGN);
    add_done(1, 0, 0, 0, 0, 0, INST_MISALIGN);
    add_done(0, 1, 1, 0, 0, 0, INST_MISALIGN);
    add_done(0, 0, 0, 0, 0, 0, INST_MISALIGN);
    add_idle(4);
    add_disp(32'h2000, 2'b11, 2'b11, 5'd7, 5'd8);  // Redirect lane 0
    add_done(3, 1, 0, 0, 0, 0, INST_MISALIGN);
    add_done(3, 0, 1, 1, 32'h3000, 0, INST_MISALIGN);
    add_idle(3);
    add_disp(32'h2100, 2'b11, 2'b11, 5'd9, 5'd10);  // Redirect last lane
    add_done(4, 0, 0, 0, 0, 0, INST_MISALIGN);
    add_done(4, 1, 1, 1, 32'h3400, 0, INST_MISALIGN);
    add_idle(3);
    add_disp(32'h4000, 2'b11, 2'b11, 5'd11, 5'd12);
    add_done(5, 0, 0, 0, 0, 0, INST_MISALIGN);
    add_done(5, 1, 1, 0, 0, 1, LOAD_FAULT);
    add_idle(3);
    add_disp(32'h5000, 2'b11, 2'b11, 5'd13, 5'd14);  // Trap and redirect on one lane
    add_done(6, 1, 0, 0, 0, 0, INST_MISALIGN);
    add_done(6, 0, 1, 1, 32'h6000, 1, ECALL);
    add_idle(3);
    add_disp(32'h7000, 2'b11, 2'b11, 5'd15, 5'd16);
    add_disp(32'h7008, 2'b11, 2'b11, 5'd17, 5'd18);
    add_disp(32'h7010, 2'b11, 2'b11, 5'd19, 5'd20);
    add_disp(32'h7018, 2'b11, 2'b11, 5'd21, 5'd22);
    add_done(8, 0, 0, 0, 0, 0, INST_MISALIGN);
    add_done(7, 1, 1, 0, 0, 0, INST_MISALIGN);
    add_done(7, 0, 0, 1, 32'h8000, 0, INST_MISALIGN);
    add_idle(5);
    add_disp(32'h8000, 2'b11, 2'b11, 5'd23, 5'd24);
    add_done(11, 1, 0, 0, 0, 0, INST_MISALIGN);
    add_done(11, 0, 1, 0, 0, 0, INST_MISALIGN);
    add_idle(3);
    // Fill the buffer, ids wrap past 15
    np = 0;
    for (int g = 12; g < 12 + ENTRY_N; g++) begin
      r = $random(seed);
      lv = 2'(r[30:0] % 3 + 1);
      add_disp(32'hA000 + 32'(g * 8), lv, 2'(r[9:8]), 5'(r[14:10]), 5'(r[19:15]));
      for (int l = 0; l < DISP_W; l++) begin
        if (lv[l]) begin
          pg[np] = g;
          pl[np] = l;
          np++;
        end
      end
    end
    for (int i = np - 1; i > 0; i--) begin
      r = $random(seed);
      j = r[30:0] % (i + 1);
      t = pg[i];
      pg[i] = pg[j];
      pg[j] = t;
      t = pl[i];
      pl[i] = pl[j];
      pl[j] = t;
    end
    for (int i = 0; i < np; i++) begin
      r = $random(seed);
      add_done(pg[i], pl[i][0], r[3], 0, 0, 0, INST_MISALIGN);
    end
    add_idle(4);
  endtask

  task automatic clear_strobes();
    disp_valid = 1'b0;
    for (int p = 0; p < PORTS; p++) begin
      done_valid[p] = 1'b0;
      done_redirect[p] = 1'b0;
      done_except[p] = 1'b0;
    end
  endtask

  task automatic apply_step(input step_t s);
    int p;
    clear_strobes();
    if (s.kind == K_DISP) begin
      check_value("o_new_cmt_id", new_cmt_id, m_in_id);
      disp_valid = 1'b1;
      disp_pc = s.pc;
      disp_lane_valid = s.lanes;
      disp_rd_valid = s.rdv;
      disp_rd_regidx = {s.rd1, s.rd0};
      g_pc[n_disp] = s.pc;
      g_id[n_disp] = m_in_id;
      g_lanes[n_disp] = s.lanes;
      g_rdv[n_disp] = s.rdv;
      g_rd[n_disp][0] = s.rd0;
      g_rd[n_disp][1] = s.rd1;
      {g_done[n_disp], g_redir[n_disp], g_exc[n_disp]} = '0;
      g_dead[n_disp] = 1'b0;
      q.push_back(n_disp);
      n_disp++;
      m_in_id++;
    end else if (s.kind == K_DONE) begin
      p = s.port;
      done_valid[p] = 1'b1;
      done_cmt_id[p] = g_id[s.grp];
      done_lane[p] = s.lane;
      done_redirect[p] = s.redir;
      done_target[p] = s.target;
      done_except[p] = s.exc;
      done_cause[p] = except_t'(s.cause);
      g_done[s.grp][s.lane] = 1'b1;
      g_redir[s.grp][s.lane] = s.redir;
      g_exc[s.grp][s.lane] = s.exc;
      g_tgt[s.grp][s.lane] = s.target;
      g_cause[s.grp][s.lane] = s.cause;
    end
  endtask

  // Expected commit from the model's head group
  task automatic check_commit(input int g, output bit flush);
    logic [1:0] any, dead, rdv;
    logic exc;
    logic [31:0] fpc, epc;
    logic [3:0] cause;
    int sel;
    any = g_redir[g] | g_exc[g];
    sel = -1;
    for (int l = DISP_W - 1; l >= 0; l--) if (any[l]) sel = l;
    {flush, exc, fpc, epc, cause, dead, rdv} = '0;
    if (g_dead[g]) begin
      dead = g_lanes[g];
    end else begin
      if ((g_done[g] | ~g_lanes[g]) != 2'b11) begin
        $display("Group %0d committed before all its lanes were done", g);
        other_errs++;
      end
      if (sel >= 0) begin
        flush = 1'b1;
        exc = g_exc[g][sel];
        fpc = exc ? 32'h0 : g_tgt[g][sel];
        epc = g_pc[g] + 32'(4 * sel);
        cause = g_cause[g][sel];
        for (int l = sel + 1; l < DISP_W; l++) dead[l] = g_lanes[g][l];
      end
      for (int l = 0; l < DISP_W; l++) begin
        rdv[l] = g_rdv[g][l] & g_lanes[g][l] & !dead[l] & !(exc && l == sel);
      end
    end
    check_value("o_cmt_id", cmt_id, g_id[g]);
    check_value("o_cmt_lanes", cmt_lanes, g_lanes[g]);
    check_value("o_cmt_dead_lanes", cmt_dead_lanes, dead);
    check_value("o_cmt_all_dead", cmt_all_dead, g_dead[g]);
    check_value("o_cmt_flush", cmt_flush, flush);
    check_value("o_cmt_flush_pc", cmt_flush_pc, fpc);
    check_value("o_cmt_except", cmt_except, exc);
    if (exc) begin
      check_value("o_cmt_cause", cmt_cause, cause);
      check_value("o_cmt_epc", cmt_epc, epc);
    end
    check_value("o_cmt_rd_valid", cmt_rd_valid, rdv);
    for (int l = 0; l < DISP_W; l++) begin
      if (rdv[l]) check_value($sformatf("o_cmt_rd_regidx[%0d]", l), cmt_rd_regidx[l], g_rd[g][l]);
    end
  endtask

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Outputs sampled mid-cycle, inputs move 10 ns after the edge
  always @(negedge clk) begin
    if (reset_n) begin
      check_value("o_credit_ret", credit_ret, prev_cmt);
      if (credit_ret) credits++;
      prev_cmt = cmt_valid;
      if (cmt_valid) begin
        commits++;
        if (q.size() == 0) begin
          $display("Commit strobe with no group outstanding at %0t", $time);
          other_errs++;
        end else begin
          head = q.pop_front();
          check_commit(head, flushed);
          if (flushed) foreach (q[i]) g_dead[q[i]] = 1'b1;  // Younger groups killed
        end
      end
    end
  end

  initial begin
    wait (table_ready);
    repeat (n_steps * 4 + 100) @(posedge clk);
    $display("Timeout: the buffer did not drain within %0d cycles", n_steps * 4 + 100);
    $display("*** TEST FAILED ***");
    $finish;
  end

  initial begin
    seed = 32'ha39fd3a6;
    reset_n = 1'b0;
    disp_pc = '0;
    disp_lane_valid = '0;
    disp_rd_valid = '0;
    disp_rd_regidx = '0;
    for (int p = 0; p < PORTS; p++) begin
      done_cmt_id[p] = '0;
      done_lane[p] = '0;
      done_target[p] = '0;
      done_cause[p] = INST_MISALIGN;
    end
    clear_strobes();
    m_in_id = '0;
    build_table();
    table_ready = 1'b1;
    repeat (8) @(posedge clk);
    #10 reset_n = 1'b1;
    check_value("o_cmt_valid", cmt_valid, 1'b0);
    check_value("o_cmt_flush", cmt_flush, 1'b0);
    check_value("o_credit_ret", credit_ret, 1'b0);
    check_value("o_new_cmt_id", new_cmt_id, 4'd0);
    for (int i = 0; i < n_steps; i++) begin
      @(posedge clk);
      #10 apply_step(steps[i]);
    end
    @(posedge clk);
    #10 clear_strobes();
    while (q.size() != 0) @(posedge clk);
    repeat (2) @(posedge clk);
    if (commits != n_disp || credits != commits) begin
      $display("Dispatched %0d groups, saw %0d commits and %0d credits", n_disp, commits,
               credits);
      other_errs++;
    end
    $display("Errors: %0d value mismatches, %0d other failures", value_errs, other_errs);
    if (value_errs + other_errs == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule
